//--- files.f
hdl/nf2_core_pkg.sv
hdl/apb_reg_decode.sv
hdl/device_id_regs.sv
hdl/mdio_regs.sv
hdl/mdio_engine.sv
hdl/nf2_core.sv
tests/nf2_core_assertions.sv
tests/tb_nf2_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the nf2_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_nf2_core

verilator --binary --timing --assert \
   --top-module "$TOP" -f files.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG_FILE"; then
   echo "Result: pass"
   exit 0
fi
echo "Result: fail"
exit 1

//--- tests/tb_nf2_core.sv
// Testbench for nf2_core with APB driver, MDIO PHY model and table-driven register checks
module tb_nf2_core;

   localparam logic [31:0] TB_DEVICE_ID  = 32'h4e46_3201;
   localparam logic [7:0]  TB_MAJOR      = 8'd2;
   localparam logic [7:0]  TB_MINOR      = 8'd7;
   localparam logic [15:0] TB_REVISION   = 16'h0105;
   localparam int          TB_MDC_DIV    = 2;
   localparam int          POLL_LIMIT    = 200;

   // Byte addresses with the block in bits 11 to 8 and the word offset in bits 7 to 2
   localparam logic [11:0] ADDR_ID          = 12'h000;
   localparam logic [11:0] ADDR_VERSION     = 12'h004;
   localparam logic [11:0] ADDR_SCRATCH     = 12'h008;
   localparam logic [11:0] ADDR_MDIO_CMD    = 12'h100;
   localparam logic [11:0] ADDR_MDIO_STATUS = 12'h104;

   logic        core_clk_int;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        phy_mdc;
   logic        phy_mdata_out;
   logic        phy_mdata_tri;
   logic        phy_mdata_in;

   int          errors;
   int          checks;
   logic [31:0] rng_state;

   // Stimulus table
   string       tbl_name[$];
   bit          tbl_write[$];
   logic [11:0] tbl_addr[$];
   logic [31:0] tbl_wdata[$];
   logic [31:0] tbl_rdata[$];
   bit          tbl_err[$];

   // PHY model state
   logic [63:0] capture;
   int          rise_count;
   logic [15:0] phy_rd_value;
   logic [15:0] phy_shift;
   logic        mdc_prev;
   logic        tri_prev;

   nf2_core #(
      .DEVICE_ID       (TB_DEVICE_ID),
      .DEVICE_MAJOR    (TB_MAJOR),
      .DEVICE_MINOR    (TB_MINOR),
      .DEVICE_REVISION (TB_REVISION),
      .MDC_DIV         (TB_MDC_DIV)
   ) UUT (
      .core_clk_int, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr, .phy_mdc, .phy_mdata_out, .phy_mdata_tri, .phy_mdata_in
   );

   initial begin
      core_clk_int = 1'b0;
      forever #5 core_clk_int = ~core_clk_int;
   end

   // ------------------------------------------------------------
   // PHY model sampling on each rising phy_mdc
   // ------------------------------------------------------------
   initial begin
      phy_mdata_in = 1'b1;
      capture      = '0;
      rise_count   = 0;
      phy_shift    = '0;
      mdc_prev     = 1'b0;
      tri_prev     = 1'b0;
      forever begin
         @(negedge core_clk_int);
         // Core takes the pin at frame start
         if (phy_mdata_tri && !tri_prev) begin
            capture    = '0;
            rise_count = 0;
            phy_shift  = phy_rd_value;
         end
         if (phy_mdc && !mdc_prev) begin
            capture    = {capture[62:0], phy_mdata_tri ? phy_mdata_out : phy_mdata_in};
            rise_count = rise_count + 1;
            if (!phy_mdata_tri && rise_count >= 48 && rise_count < 64) begin
               phy_mdata_in = phy_shift[15];
               phy_shift    = {phy_shift[14:0], 1'b1};
            end else begin
               phy_mdata_in = 1'b1;
            end
         end
         mdc_prev = phy_mdc;
         tri_prev = phy_mdata_tri;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_random(output logic [31:0] value);
      rng_state = xorshift32(rng_state);
      value     = rng_state;
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error: %s expected %b actual %b", name, expected, actual);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error: %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_frame(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error: %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic add_entry(input string name, input bit wr, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [31:0] rdata, input bit err);
      tbl_name.push_back(name);
      tbl_write.push_back(wr);
      tbl_addr.push_back(addr);
      tbl_wdata.push_back(wdata);
      tbl_rdata.push_back(rdata);
      tbl_err.push_back(err);
   endtask

   // One setup cycle and one access cycle with sampling inside the access cycle
   task automatic apb_transfer(input bit wr, input logic [11:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
      @(negedge core_clk_int);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge core_clk_int);
      penable = 1'b1;
      #1;
      rdata = prdata;
      err   = pslverr;
      checks++;
      if (pready !== 1'b1) begin
         errors++;
         $display("Error: apb_pready at address %h expected 1 actual %b", addr, pready);
      end
      @(negedge core_clk_int);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic wait_mdio_idle(input string name, output logic [31:0] status);
      logic err;
      int   polls;
      polls  = 0;
      status = 32'h1;
      while (status[0] && polls < POLL_LIMIT) begin
         apb_transfer(1'b0, ADDR_MDIO_STATUS, '0, status, err);
         polls++;
      end
      if (status[0]) begin
         errors++;
         $display("Timeout in %s, MDIO busy still high after %0d status reads", name, polls);
      end
   endtask

   initial begin
      logic [31:0] rdata;
      logic        err;
      logic [31:0] scratch_val;
      logic [31:0] rnd;
      logic [31:0] cmd;
      logic [31:0] cmd2;
      logic [31:0] status;
      logic [63:0] expected;
      errors       = 0;
      checks       = 0;
      rng_state    = 32'd98;
      rst_n        = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      phy_rd_value = '0;
      repeat (8) @(negedge core_clk_int);
      rst_n = 1'b1;
      @(negedge core_clk_int);

      // Idle pins and bus outputs out of reset
      check_bit("mdc_after_reset", 1'b0, phy_mdc);
      check_bit("tri_after_reset", 1'b0, phy_mdata_tri);
      check_bit("mdata_out_after_reset", 1'b1, phy_mdata_out);
      check_bit("pready_after_reset", 1'b0, pready);
      check_bit("pslverr_after_reset", 1'b0, pslverr);
      check_word("prdata_after_reset", '0, prdata);

      // ------------------------------------------------------------
      // Register table
      // ------------------------------------------------------------
      next_random(scratch_val);
      add_entry("status_after_reset", 1'b0, ADDR_MDIO_STATUS, '0, '0, 1'b0);
      add_entry("id_read", 1'b0, ADDR_ID, '0, TB_DEVICE_ID, 1'b0);
      add_entry("version_read", 1'b0, ADDR_VERSION, '0, {TB_MAJOR, TB_MINOR, TB_REVISION}, 1'b0);
      add_entry("scratch_write", 1'b1, ADDR_SCRATCH, scratch_val, '0, 1'b0);
      add_entry("scratch_read", 1'b0, ADDR_SCRATCH, '0, scratch_val, 1'b0);
      add_entry("id_write", 1'b1, ADDR_ID, ~TB_DEVICE_ID, '0, 1'b0);
      add_entry("id_after_write", 1'b0, ADDR_ID, '0, TB_DEVICE_ID, 1'b0);
      add_entry("low_addr_bits", 1'b0, 12'h007, '0, {TB_MAJOR, TB_MINOR, TB_REVISION}, 1'b0);
      add_entry("unknown_block_read", 1'b0, 12'h200, '0, '0, 1'b1);
      add_entry("unknown_block_write", 1'b1, 12'hF08, ~scratch_val, '0, 1'b1);
      add_entry("id_bad_offset_read", 1'b0, 12'h00C, '0, '0, 1'b1);
      add_entry("id_bad_offset_write", 1'b1, 12'h00C, ~scratch_val, '0, 1'b1);
      add_entry("mdio_bad_offset_read", 1'b0, 12'h108, '0, '0, 1'b1);
      add_entry("scratch_after_errors", 1'b0, ADDR_SCRATCH, '0, scratch_val, 1'b0);

      for (int i = 0; i < tbl_name.size(); i++) begin
         apb_transfer(tbl_write[i], tbl_addr[i], tbl_wdata[i], rdata, err);
         check_bit({tbl_name[i], "_pslverr"}, tbl_err[i], err);
         if (!tbl_write[i] || tbl_err[i]) begin
            check_word(tbl_name[i], tbl_rdata[i], rdata);
         end
      end

      // ------------------------------------------------------------
      // MDIO write frame
      // ------------------------------------------------------------
      next_random(rnd);
      cmd = {4'b0000, 2'b01, rnd[4:0], rnd[9:5], rnd[31:16]};
      apb_transfer(1'b1, ADDR_MDIO_CMD, cmd, rdata, err);
      check_bit("mdio_write_cmd_pslverr", 1'b0, err);
      apb_transfer(1'b0, ADDR_MDIO_STATUS, '0, status, err);
      check_bit("mdio_write_busy", 1'b1, status[0]);
      wait_mdio_idle("mdio_write", status);
      check_word("mdio_write_bit_count", 32'd64, rise_count);
      expected = {32'hFFFF_FFFF, 2'b01, 2'b01, rnd[4:0], rnd[9:5], 2'b10, rnd[31:16]};
      check_frame("mdio_write_frame", expected, capture);

      // MDIO read with data returned by the PHY model
      next_random(rnd);
      phy_rd_value = rnd[31:16];
      cmd = {4'b0000, 2'b10, rnd[4:0], rnd[9:5], 16'h0000};
      apb_transfer(1'b1, ADDR_MDIO_CMD, cmd, rdata, err);
      check_bit("mdio_read_cmd_pslverr", 1'b0, err);
      wait_mdio_idle("mdio_read", status);
      check_word("mdio_read_status", {phy_rd_value, 16'h0000}, status);
      expected = {32'hFFFF_FFFF, 2'b01, 2'b10, rnd[4:0], rnd[9:5], 18'h0};
      check_frame("mdio_read_header", expected, capture & 64'hFFFF_FFFF_FFFC_0000);
      check_word("mdio_read_wire_data", {16'h0000, phy_rd_value}, {16'h0000, capture[15:0]});

      // Second command while the first frame runs
      next_random(rnd);
      cmd = {4'b0000, 2'b01, rnd[4:0], rnd[9:5], rnd[31:16]};
      next_random(rnd);
      cmd2 = {4'b0000, 2'b10, rnd[4:0], rnd[9:5], rnd[31:16]};
      apb_transfer(1'b1, ADDR_MDIO_CMD, cmd, rdata, err);
      check_bit("mdio_first_cmd_pslverr", 1'b0, err);
      apb_transfer(1'b1, ADDR_MDIO_CMD, cmd2, rdata, err);
      check_bit("mdio_busy_cmd_pslverr", 1'b1, err);
      check_word("mdio_busy_cmd_rdata", '0, rdata);
      apb_transfer(1'b0, ADDR_MDIO_CMD, '0, rdata, err);
      check_word("mdio_cmd_readback", cmd, rdata);
      wait_mdio_idle("mdio_busy", status);
      expected = {32'hFFFF_FFFF, 2'b01, cmd[27:16], 2'b10, cmd[15:0]};
      check_frame("mdio_busy_frame", expected, capture);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- tests/nf2_core_assertions.sv
// Concurrent checks on the APB error response and the idle MDIO pins with their bind to nf2_core
module nf2_core_assertions (
   input logic core_clk_int,
   input logic rst_n,
   input logic psel,
   input logic penable,
   input logic pslverr,
   input logic busy,
   input logic phy_mdc,
   input logic phy_mdata_tri
);

   // Error response only inside an access cycle
   a_pslverr_access: assert property (@(posedge core_clk_int) disable iff (!rst_n)
      pslverr |-> (psel && penable))
      else $error("pslverr high outside an APB access cycle");

   // MDC holds still between frames
   a_mdc_idle: assert property (@(posedge core_clk_int) disable iff (!rst_n)
      (!busy && !$past(busy)) |-> $stable(phy_mdc))
      else $error("phy_mdc toggled while the MDIO engine was idle");

   // Pin released whenever no frame runs
   a_tri_idle: assert property (@(posedge core_clk_int) disable iff (!rst_n)
      !busy |-> !phy_mdata_tri)
      else $error("phy_mdata_tri high while the MDIO engine was idle");

endmodule

bind nf2_core nf2_core_assertions assertions (
   .core_clk_int  (core_clk_int),
   .rst_n         (rst_n),
   .psel          (psel),
   .penable       (penable),
   .pslverr       (pslverr),
   .busy          (busy),
   .phy_mdc       (phy_mdc),
   .phy_mdata_tri (phy_mdata_tri)
);

//--- hdl/nf2_core.sv
// Top level joining the APB decoder, the ID registers and the MDIO controller
module nf2_core #(
   parameter logic [31:0] DEVICE_ID       = 32'h4e46_3243,
   parameter logic [7:0]  DEVICE_MAJOR    = 8'd1,
   parameter logic [7:0]  DEVICE_MINOR    = 8'd2,
   parameter logic [15:0] DEVICE_REVISION = 16'd3,
   parameter int          MDC_DIV         = 4
) (
   input  logic                                     core_clk_int,
   input  logic                                     rst_n,
   input  logic                                     psel,
   input  logic                                     penable,
   input  logic                                     pwrite,
   input  logic [nf2_core_pkg::APB_ADDR_WIDTH-1:0]  paddr,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]  pwdata,
   output logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]  prdata,
   output logic                                     pready,
   output logic                                     pslverr,
   output logic                                     phy_mdc,
   output logic                                     phy_mdata_out,
   output logic                                     phy_mdata_tri,
   input  logic                                     phy_mdata_in
);

   logic                                       id_sel;
   logic                                       mdio_sel;
   logic                                       reg_wr;
   logic [nf2_core_pkg::REG_OFFSET_WIDTH-1:0]  reg_offset;
   logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]    reg_wr_data;
   logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]    id_rd_data;
   logic                                       id_err;
   logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]    mdio_rd_data;
   logic                                       mdio_err;

   // Command path between the MDIO registers and the engine
   logic                                       start;
   logic                                       busy;
   nf2_core_pkg::mdio_op_e                     op;
   logic [nf2_core_pkg::PHY_ADDR_WIDTH-1:0]    phy_addr;
   logic [nf2_core_pkg::PHY_REG_WIDTH-1:0]     phy_reg;
   logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]   wr_data;
   logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]   rd_data;

   // ------------------------------------------------------------
   // Register bus
   // ------------------------------------------------------------
   apb_reg_decode apb_reg_decode (
      .core_clk_int, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr, .id_sel, .mdio_sel, .reg_wr, .reg_offset,
      .reg_wr_data, .id_rd_data, .id_err, .mdio_rd_data, .mdio_err
   );

   device_id_regs #(
      .DEVICE_ID       (DEVICE_ID),
      .DEVICE_MAJOR    (DEVICE_MAJOR),
      .DEVICE_MINOR    (DEVICE_MINOR),
      .DEVICE_REVISION (DEVICE_REVISION)
   ) device_id_regs (
      .core_clk_int, .rst_n,
      .reg_sel     (id_sel),
      .reg_wr, .reg_offset, .reg_wr_data,
      .reg_rd_data (id_rd_data),
      .reg_err     (id_err)
   );

   // ------------------------------------------------------------
   // PHY management
   // ------------------------------------------------------------
   mdio_regs mdio_regs (
      .core_clk_int, .rst_n,
      .reg_sel     (mdio_sel),
      .reg_wr, .reg_offset, .reg_wr_data,
      .reg_rd_data (mdio_rd_data),
      .reg_err     (mdio_err),
      .busy, .rd_data, .start, .op, .phy_addr, .phy_reg, .wr_data
   );

   mdio_engine #(.MDC_DIV(MDC_DIV)) mdio_engine (
      .core_clk_int, .rst_n, .start, .op, .phy_addr, .phy_reg, .wr_data,
      .busy, .rd_data, .phy_mdc, .phy_mdata_out, .phy_mdata_tri, .phy_mdata_in
   );

endmodule

//--- hdl/mdio_engine.sv
// MDC divider and clause-22 frame shifter with read data capture
module mdio_engine #(
   parameter int MDC_DIV = 4
) (
   input  logic                                        core_clk_int,
   input  logic                                        rst_n,
   input  logic                                        start,
   input  nf2_core_pkg::mdio_op_e                      op,
   input  logic [nf2_core_pkg::PHY_ADDR_WIDTH-1:0]     phy_addr,
   input  logic [nf2_core_pkg::PHY_REG_WIDTH-1:0]      phy_reg,
   input  logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]    wr_data,
   output logic                                        busy,
   output logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]    rd_data,
   output logic                                        phy_mdc,
   output logic                                        phy_mdata_out,
   output logic                                        phy_mdata_tri,
   input  logic                                        phy_mdata_in
);

   localparam int DIV_W   = (MDC_DIV > 1) ? $clog2(MDC_DIV) : 1;
   localparam int PRE_END = nf2_core_pkg::MDIO_PREAMBLE_BITS - 1;
   localparam int HDR_END = PRE_END + 4 + nf2_core_pkg::PHY_ADDR_WIDTH
                            + nf2_core_pkg::PHY_REG_WIDTH;
   localparam int TA_END  = HDR_END + 2;
   localparam int LAST    = TA_END + nf2_core_pkg::MDIO_DATA_WIDTH;

   nf2_core_pkg::mdio_state_e state;
   nf2_core_pkg::mdio_state_e state_next;
   logic [DIV_W-1:0]          div_cnt;
   logic                      div_end;
   logic [5:0]                bit_cnt;
   logic [5:0]                cnt_next;
   logic [31:0]               frame_word;
   logic                      is_read;

   // Everything after the preamble with the first wire bit at the top
   assign frame_word = {2'b01, op, phy_addr, phy_reg, 2'b10, wr_data};
   assign is_read    = (op == nf2_core_pkg::MDIO_OP_READ);
   assign div_end    = (div_cnt == DIV_W'(MDC_DIV - 1));
   assign cnt_next   = bit_cnt + 6'd1;
   assign busy       = (state != nf2_core_pkg::MDIO_IDLE);

   // Phase that the next bit belongs to
   always_comb begin
      state_next = state;
      case (state)
         nf2_core_pkg::MDIO_PREAMBLE: begin
            if (bit_cnt == 6'(PRE_END)) state_next = nf2_core_pkg::MDIO_HEADER;
         end
         nf2_core_pkg::MDIO_HEADER: begin
            if (bit_cnt == 6'(HDR_END)) state_next = nf2_core_pkg::MDIO_TURNAROUND;
         end
         nf2_core_pkg::MDIO_TURNAROUND: begin
            if (bit_cnt == 6'(TA_END)) state_next = nf2_core_pkg::MDIO_DATA;
         end
         default: state_next = state;
      endcase
   end

   // ------------------------------------------------------------
   // Divider, bit counter and pin drive
   // ------------------------------------------------------------
   always_ff @(posedge core_clk_int) begin
      if (!rst_n) begin
         state         <= nf2_core_pkg::MDIO_IDLE;
         div_cnt       <= '0;
         bit_cnt       <= '0;
         phy_mdc       <= 1'b0;
         phy_mdata_out <= 1'b1;
         phy_mdata_tri <= 1'b0;
         rd_data       <= '0;
      end else if (state == nf2_core_pkg::MDIO_IDLE) begin
         div_cnt <= '0;
         bit_cnt <= '0;
         if (start) begin
            // First preamble bit goes out at once
            state         <= nf2_core_pkg::MDIO_PREAMBLE;
            phy_mdata_out <= 1'b1;
            phy_mdata_tri <= 1'b1;
         end
      end else begin
         div_cnt <= div_end ? '0 : div_cnt + DIV_W'(1);
         if (div_end) begin
            phy_mdc <= ~phy_mdc;
            if (!phy_mdc) begin
               // PHY data is sampled on the rising edge
               if (state == nf2_core_pkg::MDIO_DATA && is_read) begin
                  rd_data <= {rd_data[nf2_core_pkg::MDIO_DATA_WIDTH-2:0], phy_mdata_in};
               end
            end else if (bit_cnt == 6'(LAST)) begin
               state         <= nf2_core_pkg::MDIO_IDLE;
               phy_mdata_out <= 1'b1;
               phy_mdata_tri <= 1'b0;
            end else begin
               // Falling edge moves to the next bit
               state         <= state_next;
               bit_cnt       <= cnt_next;
               phy_mdata_out <= cnt_next[5] ? frame_word[~cnt_next[4:0]] : 1'b1;
               phy_mdata_tri <= ~(is_read && cnt_next > 6'(HDR_END));
            end
         end
      end
   end

endmodule

//--- hdl/mdio_regs.sv
// MDIO command and status registers in front of the serial engine
module mdio_regs (
   input  logic                                        core_clk_int,
   input  logic                                        rst_n,
   input  logic                                        reg_sel,
   input  logic                                        reg_wr,
   input  logic [nf2_core_pkg::REG_OFFSET_WIDTH-1:0]   reg_offset,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     reg_wr_data,
   output logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     reg_rd_data,
   output logic                                        reg_err,
   input  logic                                        busy,
   input  logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]    rd_data,
   output logic                                        start,
   output nf2_core_pkg::mdio_op_e                      op,
   output logic [nf2_core_pkg::PHY_ADDR_WIDTH-1:0]     phy_addr,
   output logic [nf2_core_pkg::PHY_REG_WIDTH-1:0]      phy_reg,
   output logic [nf2_core_pkg::MDIO_DATA_WIDTH-1:0]    wr_data
);

   logic cmd_wr;
   logic cmd_rejected;

   assign cmd_wr       = reg_sel & reg_wr & (reg_offset == nf2_core_pkg::MDIO_CMD_OFFSET);
   assign cmd_rejected = cmd_wr & busy;

   // Start lines up with the access cycle, so busy is up right after the write
   assign start = cmd_wr & ~busy;

   // ------------------------------------------------------------
   // Command fields, stable for the whole frame
   // ------------------------------------------------------------
   always_ff @(posedge core_clk_int) begin
      if (!rst_n) begin
         op       <= nf2_core_pkg::MDIO_OP_WRITE;
         phy_addr <= '0;
         phy_reg  <= '0;
         wr_data  <= '0;
      end else if (start) begin
         op       <= nf2_core_pkg::mdio_op_e'(reg_wr_data[27:26]);
         phy_addr <= reg_wr_data[25:21];
         phy_reg  <= reg_wr_data[20:16];
         wr_data  <= reg_wr_data[15:0];
      end
   end

   // Read back and error decode
   always_comb begin
      reg_rd_data = '0;
      reg_err     = 1'b0;
      case (reg_offset)
         nf2_core_pkg::MDIO_CMD_OFFSET: begin
            reg_rd_data = {4'b0, op, phy_addr, phy_reg, wr_data};
            reg_err     = cmd_rejected;
         end
         nf2_core_pkg::MDIO_STATUS_OFFSET: begin
            reg_rd_data = {rd_data, 15'b0, busy};
         end
         default: reg_err = reg_sel;
      endcase
   end

endmodule

//--- hdl/device_id_regs.sv
// Device ID, version word and scratch register block
module device_id_regs #(
   parameter logic [31:0] DEVICE_ID       = 32'h0,
   parameter logic [7:0]  DEVICE_MAJOR    = 8'h0,
   parameter logic [7:0]  DEVICE_MINOR    = 8'h0,
   parameter logic [15:0] DEVICE_REVISION = 16'h0
) (
   input  logic                                        core_clk_int,
   input  logic                                        rst_n,
   input  logic                                        reg_sel,
   input  logic                                        reg_wr,
   input  logic [nf2_core_pkg::REG_OFFSET_WIDTH-1:0]   reg_offset,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     reg_wr_data,
   output logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     reg_rd_data,
   output logic                                        reg_err
);

   logic [nf2_core_pkg::REG_DATA_WIDTH-1:0] scratch;

   // Only the scratch word is writable
   always_ff @(posedge core_clk_int) begin
      if (!rst_n) begin
         scratch <= '0;
      end else if (reg_sel && reg_wr &&
                   reg_offset == nf2_core_pkg::DEV_SCRATCH_OFFSET) begin
         scratch <= reg_wr_data;
      end
   end

   always_comb begin
      reg_rd_data = '0;
      reg_err     = 1'b0;
      case (reg_offset)
         nf2_core_pkg::DEV_ID_OFFSET:      reg_rd_data = DEVICE_ID;
         nf2_core_pkg::DEV_VERSION_OFFSET: begin
            reg_rd_data = {DEVICE_MAJOR, DEVICE_MINOR, DEVICE_REVISION};
         end
         nf2_core_pkg::DEV_SCRATCH_OFFSET: reg_rd_data = scratch;
         default:                          reg_err     = reg_sel;
      endcase
   end

endmodule

//--- hdl/apb_reg_decode.sv
// APB slave with block decode, read data return and error response
module apb_reg_decode (
   input  logic                                        core_clk_int,
   input  logic                                        rst_n,
   input  logic                                        psel,
   input  logic                                        penable,
   input  logic                                        pwrite,
   input  logic [nf2_core_pkg::APB_ADDR_WIDTH-1:0]     paddr,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     pwdata,
   output logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     prdata,
   output logic                                        pready,
   output logic                                        pslverr,
   output logic                                        id_sel,
   output logic                                        mdio_sel,
   output logic                                        reg_wr,
   output logic [nf2_core_pkg::REG_OFFSET_WIDTH-1:0]   reg_offset,
   output logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     reg_wr_data,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     id_rd_data,
   input  logic                                        id_err,
   input  logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]     mdio_rd_data,
   input  logic                                        mdio_err
);

   nf2_core_pkg::reg_block_e                     blk;
   logic                                         setup_seen;
   logic                                         access;
   logic                                         blk_err;
   logic                                         sel_err;
   logic [nf2_core_pkg::REG_DATA_WIDTH-1:0]      sel_data;

   // Remember the setup phase so that only a proper access cycle counts
   always_ff @(posedge core_clk_int) begin
      if (!rst_n) begin
         setup_seen <= 1'b0;
      end else begin
         setup_seen <= psel & ~penable;
      end
   end

   assign access = psel & penable & setup_seen;
   assign pready = access;

   // ------------------------------------------------------------
   // Block select
   // ------------------------------------------------------------
   assign blk = nf2_core_pkg::reg_block_e'(
      paddr[nf2_core_pkg::APB_ADDR_WIDTH-1 -: nf2_core_pkg::BLOCK_SEL_WIDTH]);

   assign reg_offset  = paddr[2 +: nf2_core_pkg::REG_OFFSET_WIDTH];
   assign reg_wr      = access & pwrite;
   assign reg_wr_data = pwdata;

   always_comb begin
      id_sel   = 1'b0;
      mdio_sel = 1'b0;
      blk_err  = 1'b0;
      sel_data = '0;
      sel_err  = 1'b0;
      case (blk)
         nf2_core_pkg::BLK_DEVICE_ID: begin
            id_sel   = access;
            sel_data = id_rd_data;
            sel_err  = id_err;
         end
         nf2_core_pkg::BLK_MDIO: begin
            mdio_sel = access;
            sel_data = mdio_rd_data;
            sel_err  = mdio_err;
         end
         default: blk_err = 1'b1;
      endcase
   end

   // Error response carries no data
   assign pslverr = access & (blk_err | sel_err);
   assign prdata  = (access && !pslverr) ? sel_data : '0;

endmodule

//--- hdl/nf2_core_pkg.sv
// Register path widths, block and register offsets, MDIO opcodes and engine states
package nf2_core_pkg;

   // ------------------------------------------------------------
   // Register bus widths
   // ------------------------------------------------------------
   localparam int APB_ADDR_WIDTH   = 12;
   localparam int REG_DATA_WIDTH   = 32;

   // Block number in byte address bits 11 to 8
   localparam int BLOCK_SEL_WIDTH  = 4;

   // Word offset in byte address bits 7 to 2
   localparam int REG_OFFSET_WIDTH = 6;

   // ------------------------------------------------------------
   // MDIO frame fields
   // ------------------------------------------------------------
   localparam int PHY_ADDR_WIDTH     = 5;
   localparam int PHY_REG_WIDTH      = 5;
   localparam int MDIO_DATA_WIDTH    = 16;
   localparam int MDIO_PREAMBLE_BITS = 32;

   // Register blocks behind the decoder
   typedef enum logic [BLOCK_SEL_WIDTH-1:0] {
      BLK_DEVICE_ID = 4'd0,
      BLK_MDIO      = 4'd1
   } reg_block_e;

   // Clause-22 opcodes
   typedef enum logic [1:0] {
      MDIO_OP_WRITE = 2'b01,
      MDIO_OP_READ  = 2'b10
   } mdio_op_e;

   // Serial engine phases
   typedef enum logic [2:0] {
      MDIO_IDLE,
      MDIO_PREAMBLE,
      MDIO_HEADER,
      MDIO_TURNAROUND,
      MDIO_DATA
   } mdio_state_e;

   // ------------------------------------------------------------
   // Word offsets inside each block
   // ------------------------------------------------------------
   localparam logic [REG_OFFSET_WIDTH-1:0] DEV_ID_OFFSET      = 6'd0;
   localparam logic [REG_OFFSET_WIDTH-1:0] DEV_VERSION_OFFSET = 6'd1;
   localparam logic [REG_OFFSET_WIDTH-1:0] DEV_SCRATCH_OFFSET = 6'd2;

   localparam logic [REG_OFFSET_WIDTH-1:0] MDIO_CMD_OFFSET    = 6'd0;
   localparam logic [REG_OFFSET_WIDTH-1:0] MDIO_STATUS_OFFSET = 6'd1;

endpackage
